// File: common/rv_pkg.sv
// RV64 widths and encodings shared by the core; ALU, branch and memory-op codes keep the legacy 5/3-bit maps
`default_nettype none

package rv_pkg;

  localparam int XLEN = 64;

  localparam logic [XLEN-1:0] RESET_PC = 64'h0000_0000_8000_0000;

  localparam logic [6:0] OPC_LUI     = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC   = 7'b0010111;
  localparam logic [6:0] OPC_JAL     = 7'b1101111;
  localparam logic [6:0] OPC_JALR    = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH  = 7'b1100011;
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_STORE   = 7'b0100011;
  localparam logic [6:0] OPC_OPIMM   = 7'b0010011;
  localparam logic [6:0] OPC_OPIMM32 = 7'b0011011;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_OP32    = 7'b0111011;
  localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

  localparam logic [4:0] ALU_ADD     = 5'b00000;
  localparam logic [4:0] ALU_SLL     = 5'b00001;
  localparam logic [4:0] ALU_COPYIMM = 5'b00011;
  localparam logic [4:0] ALU_XOR     = 5'b00100;
  localparam logic [4:0] ALU_SRL     = 5'b00101;
  localparam logic [4:0] ALU_OR      = 5'b00110;
  localparam logic [4:0] ALU_AND     = 5'b00111;
  localparam logic [4:0] ALU_SUB     = 5'b01000;
  localparam logic [4:0] ALU_SLTU    = 5'b01010;
  localparam logic [4:0] ALU_SRA     = 5'b01101;
  localparam logic [4:0] ALU_DIV     = 5'b11011; // signed
  localparam logic [4:0] ALU_MUL     = 5'b11100;
  localparam logic [4:0] ALU_REM     = 5'b11101; // signed

  localparam logic [2:0] BR_NONE = 3'b000;
  localparam logic [2:0] BR_JAL  = 3'b001;
  localparam logic [2:0] BR_JALR = 3'b010;
  localparam logic [2:0] BR_EQ   = 3'b100;
  localparam logic [2:0] BR_NE   = 3'b101;
  localparam logic [2:0] BR_LT   = 3'b110; // also bltu
  localparam logic [2:0] BR_GE   = 3'b111; // also bgeu

  localparam logic [2:0] MOP_SB   = 3'b000;
  localparam logic [2:0] MOP_UB   = 3'b001;
  localparam logic [2:0] MOP_SH   = 3'b010;
  localparam logic [2:0] MOP_UH   = 3'b011;
  localparam logic [2:0] MOP_SW   = 3'b100;
  localparam logic [2:0] MOP_UW   = 3'b101;
  localparam logic [2:0] MOP_SD   = 3'b110;
  localparam logic [2:0] MOP_NONE = 3'b111;

  localparam logic ASRC_RS1 = 1'b0;
  localparam logic ASRC_PC  = 1'b1;

  localparam logic [1:0] BSRC_RS2  = 2'b00;
  localparam logic [1:0] BSRC_IMM  = 2'b01;
  localparam logic [1:0] BSRC_FOUR = 2'b10; // link value pc+4

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm11_0;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm11_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm4_0;
    logic [6:0] opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm12;
    logic [5:0] imm10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm4_1;
    logic       imm11;
    logic [6:0] opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm31_12;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm20;
    logic [9:0] imm10_1;
    logic       imm11;
    logic [7:0] imm19_12;
    logic [4:0] rd;
    logic [6:0] opcode;
  } j_fmt_t;

  typedef union packed {
    logic [31:0] raw;
    r_fmt_t      r;
    i_fmt_t      i;
    s_fmt_t      s;
    b_fmt_t      b;
    u_fmt_t      u;
    j_fmt_t      j;
  } inst_u;

endpackage

`default_nettype wire

// File: idu/rv_idu.sv
// decodes the supported RV64IM subset only and flags every other word as illegal while valid
`timescale 1ns/1ns
`default_nettype none

module rv_idu
  import rv_pkg::*;
(
  input  inst_u           i_inst,
  input  logic            i_valid,
  output logic [4:0]      o_ra,
  output logic [4:0]      o_rb,
  output logic [4:0]      o_rd,
  output logic [XLEN-1:0] o_imm,
  output logic            o_a_src,
  output logic [1:0]      o_b_src,
  output logic [4:0]      o_alu_ctr,
  output logic            o_word_cut,
  output logic [2:0]      o_branch,
  output logic            o_br_unsigned,
  output logic            o_reg_wr,
  output logic            o_mem_wr,
  output logic            o_mem_to_reg,
  output logic [2:0]      o_mem_op,
  output logic            o_ebreak,
  output logic            o_illegal
);

  wire [6:0] opc = i_inst.r.opcode;
  wire [2:0] f3  = i_inst.r.funct3;
  wire [6:0] f7  = i_inst.r.funct7;

  wire [XLEN-1:0] imm_i = {{52{i_inst.i.imm11_0[11]}}, i_inst.i.imm11_0};
  wire [XLEN-1:0] imm_s = {{52{i_inst.s.imm11_5[6]}}, i_inst.s.imm11_5, i_inst.s.imm4_0};
  wire [XLEN-1:0] imm_b = {{52{i_inst.b.imm12}}, i_inst.b.imm11, i_inst.b.imm10_5,
                           i_inst.b.imm4_1, 1'b0};
  wire [XLEN-1:0] imm_u = {{32{i_inst.u.imm31_12[19]}}, i_inst.u.imm31_12, 12'd0};
  wire [XLEN-1:0] imm_j = {{44{i_inst.j.imm20}}, i_inst.j.imm19_12, i_inst.j.imm11,
                           i_inst.j.imm10_1, 1'b0};

  wire is_br    = opc == OPC_BRANCH;
  wire is_ld    = opc == OPC_LOAD;
  wire is_st    = opc == OPC_STORE;
  wire is_opi   = opc == OPC_OPIMM;
  wire is_op    = opc == OPC_OP;
  wire is_op32  = opc == OPC_OP32;
  wire f7_zero  = f7 == 7'b0000000;
  wire f7_alt   = f7 == 7'b0100000;
  wire f7_muldv = f7 == 7'b0000001;

  wire inst_lui    = opc == OPC_LUI;
  wire inst_auipc  = opc == OPC_AUIPC;
  wire inst_jal    = opc == OPC_JAL;
  wire inst_jalr   = (opc == OPC_JALR) & (f3 == 3'b000);
  wire inst_beq    = is_br & (f3 == 3'b000);
  wire inst_bne    = is_br & (f3 == 3'b001);
  wire inst_blt    = is_br & (f3 == 3'b100);
  wire inst_bge    = is_br & (f3 == 3'b101);
  wire inst_bltu   = is_br & (f3 == 3'b110);
  wire inst_bgeu   = is_br & (f3 == 3'b111);
  wire inst_lh     = is_ld & (f3 == 3'b001);
  wire inst_lw     = is_ld & (f3 == 3'b010);
  wire inst_ld     = is_ld & (f3 == 3'b011);
  wire inst_lbu    = is_ld & (f3 == 3'b100);
  wire inst_lhu    = is_ld & (f3 == 3'b101);
  wire inst_sb     = is_st & (f3 == 3'b000);
  wire inst_sh     = is_st & (f3 == 3'b001);
  wire inst_sw     = is_st & (f3 == 3'b010);
  wire inst_sd     = is_st & (f3 == 3'b011);
  wire inst_addi   = is_opi & (f3 == 3'b000);
  wire inst_slli   = is_opi & (f3 == 3'b001) & (f7[6:1] == 6'b000000); // 6-bit shamt
  wire inst_sltiu  = is_opi & (f3 == 3'b011);
  wire inst_xori   = is_opi & (f3 == 3'b100);
  wire inst_srli   = is_opi & (f3 == 3'b101) & (f7[6:1] == 6'b000000);
  wire inst_srai   = is_opi & (f3 == 3'b101) & (f7[6:1] == 6'b010000);
  wire inst_andi   = is_opi & (f3 == 3'b111);
  wire inst_addiw  = (opc == OPC_OPIMM32) & (f3 == 3'b000);
  wire inst_add    = is_op & (f3 == 3'b000) & f7_zero;
  wire inst_sub    = is_op & (f3 == 3'b000) & f7_alt;
  wire inst_or     = is_op & (f3 == 3'b110) & f7_zero;
  wire inst_mul    = is_op & (f3 == 3'b000) & f7_muldv;
  wire inst_addw   = is_op32 & (f3 == 3'b000) & f7_zero;
  wire inst_subw   = is_op32 & (f3 == 3'b000) & f7_alt;
  wire inst_sllw   = is_op32 & (f3 == 3'b001) & f7_zero;
  wire inst_mulw   = is_op32 & (f3 == 3'b000) & f7_muldv;
  wire inst_divw   = is_op32 & (f3 == 3'b100) & f7_muldv;
  wire inst_remw   = is_op32 & (f3 == 3'b110) & f7_muldv;
  wire inst_ebreak = i_inst.raw == 32'h0010_0073; // exact encoding only

  wire inst_load  = |{inst_lh, inst_lhu, inst_lw, inst_lbu, inst_ld};
  wire type_s     = |{inst_sb, inst_sh, inst_sw, inst_sd};
  wire type_b     = |{inst_beq, inst_bne, inst_blt, inst_bge, inst_bltu, inst_bgeu};
  wire type_u     = inst_lui | inst_auipc;
  wire type_r     = |{inst_add, inst_sub, inst_or, inst_mul, inst_addw, inst_subw,
                      inst_sllw, inst_mulw, inst_divw, inst_remw};
  wire type_i     = |{inst_jalr, inst_load, inst_addi, inst_slli, inst_sltiu, inst_xori,
                      inst_srli, inst_srai, inst_andi, inst_addiw};
  wire legal      = |{type_r, type_i, type_s, type_b, type_u, inst_jal, inst_ebreak};

  assign o_ra          = i_inst.r.rs1;
  assign o_rb          = i_inst.r.rs2;
  assign o_rd          = i_inst.r.rd;
  assign o_a_src       = (inst_jal | inst_jalr | inst_auipc) ? ASRC_PC : ASRC_RS1;
  assign o_word_cut    = |{inst_addiw, inst_addw, inst_subw, inst_sllw, inst_mulw,
                           inst_divw, inst_remw};
  assign o_br_unsigned = inst_bltu | inst_bgeu;
  assign o_mem_to_reg  = inst_load;
  assign o_reg_wr      = i_valid & (type_r | type_i | type_u | inst_jal); // ebreak excluded
  assign o_mem_wr      = i_valid & type_s;
  assign o_ebreak      = i_valid & inst_ebreak;
  assign o_illegal     = i_valid & ~legal;

  always_comb begin
    if (type_s) o_imm = imm_s;
    else if (type_b) o_imm = imm_b;
    else if (type_u) o_imm = imm_u;
    else if (inst_jal) o_imm = imm_j;
    else o_imm = imm_i;
  end

  always_comb begin
    if (inst_jal | inst_jalr) o_b_src = BSRC_FOUR;
    else if (type_i | type_u | type_s) o_b_src = BSRC_IMM;
    else o_b_src = BSRC_RS2;
  end

  always_comb begin
    o_alu_ctr = ALU_ADD; // address, link and plain adds
    if (inst_lui) o_alu_ctr = ALU_COPYIMM;
    else if (type_b | inst_sub | inst_subw) o_alu_ctr = ALU_SUB;
    else if (inst_sltiu) o_alu_ctr = ALU_SLTU;
    else if (inst_xori) o_alu_ctr = ALU_XOR;
    else if (inst_andi) o_alu_ctr = ALU_AND;
    else if (inst_or) o_alu_ctr = ALU_OR;
    else if (inst_slli | inst_sllw) o_alu_ctr = ALU_SLL;
    else if (inst_srli) o_alu_ctr = ALU_SRL;
    else if (inst_srai) o_alu_ctr = ALU_SRA;
    else if (inst_mul | inst_mulw) o_alu_ctr = ALU_MUL;
    else if (inst_divw) o_alu_ctr = ALU_DIV;
    else if (inst_remw) o_alu_ctr = ALU_REM;
  end

  always_comb begin
    o_branch = BR_NONE;
    if (inst_jal) o_branch = BR_JAL;
    else if (inst_jalr) o_branch = BR_JALR;
    else if (inst_beq) o_branch = BR_EQ;
    else if (inst_bne) o_branch = BR_NE;
    else if (inst_blt | inst_bltu) o_branch = BR_LT;
    else if (inst_bge | inst_bgeu) o_branch = BR_GE;
  end

  always_comb begin
    o_mem_op = MOP_NONE;
    if (inst_sb) o_mem_op = MOP_SB;
    else if (inst_lbu) o_mem_op = MOP_UB;
    else if (inst_sh | inst_lh) o_mem_op = MOP_SH;
    else if (inst_lhu) o_mem_op = MOP_UH;
    else if (inst_sw | inst_lw) o_mem_op = MOP_SW;
    else if (inst_sd | inst_ld) o_mem_op = MOP_SD;
  end

endmodule

`default_nettype wire

// File: exu/rv_alu.sv
// combinational ALU where word_cut works on the low 32 bits and div/rem are signed only
`timescale 1ns/1ns
`default_nettype none

module rv_alu
  import rv_pkg::*;
(
  input  logic [XLEN-1:0] i_pc,
  input  logic [XLEN-1:0] i_rs1,
  input  logic [XLEN-1:0] i_rs2,
  input  logic [XLEN-1:0] i_imm,
  input  logic            i_a_src,
  input  logic [1:0]      i_b_src,
  input  logic [4:0]      i_alu_ctr,
  input  logic            i_word_cut,
  output logic [XLEN-1:0] o_result
);

  logic [XLEN-1:0]        op_a;
  logic [XLEN-1:0]        op_b;
  logic [XLEN-1:0]        res;
  logic [5:0]             shamt;
  logic [XLEN-1:0]        shr_src;
  logic signed [XLEN-1:0] dvd;
  logic signed [XLEN-1:0] dvs;

  assign op_a = (i_a_src == ASRC_PC) ? i_pc : i_rs1;

  always_comb begin
    case (i_b_src)
      BSRC_IMM:  op_b = i_imm;
      BSRC_FOUR: op_b = 64'd4;
      default:   op_b = i_rs2;
    endcase
  end

  assign shamt = i_word_cut ? {1'b0, op_b[4:0]} : op_b[5:0];

  // right shifts of a word must not pull in the upper half
  assign shr_src = !i_word_cut ? op_a :
                   (i_alu_ctr == ALU_SRA) ? {{32{op_a[31]}}, op_a[31:0]} : {32'd0, op_a[31:0]};
  assign dvd = i_word_cut ? {{32{op_a[31]}}, op_a[31:0]} : op_a;
  assign dvs = i_word_cut ? {{32{op_b[31]}}, op_b[31:0]} : op_b;

  always_comb begin
    case (i_alu_ctr)
      ALU_ADD:     res = op_a + op_b;
      ALU_SUB:     res = op_a - op_b;
      ALU_SLL:     res = op_a << shamt;
      ALU_SRL:     res = shr_src >> shamt;
      ALU_SRA:     res = $signed(shr_src) >>> shamt;
      ALU_XOR:     res = op_a ^ op_b;
      ALU_OR:      res = op_a | op_b;
      ALU_AND:     res = op_a & op_b;
      ALU_SLTU:    res = {{(XLEN-1){1'b0}}, op_a < op_b};
      ALU_COPYIMM: res = op_b;
      ALU_MUL:     res = op_a * op_b; // low half, sign does not matter
      ALU_DIV: begin
        if (dvs == '0) res = '1;
        else res = dvd / dvs;
      end
      ALU_REM: begin
        if (dvs == '0) res = dvd;
        else res = dvd % dvs;
      end
      default:     res = '0;
    endcase
  end

  assign o_result = i_word_cut ? {{32{res[31]}}, res[31:0]} : res;

endmodule

`default_nettype wire

// File: exu/rv_lsu.sv
// naturally aligned accesses only and the data bus is one 64-bit doubleword lane set
`timescale 1ns/1ns
`default_nettype none

module rv_lsu
  import rv_pkg::*;
(
  input  logic [XLEN-1:0] i_addr,
  input  logic [XLEN-1:0] i_rs2,
  input  logic [2:0]      i_mem_op,
  input  logic            i_mem_wr,
  input  logic            i_mem_to_reg,
  input  logic [XLEN-1:0] i_alu_res,
  input  logic [XLEN-1:0] i_mem_rdata,
  output logic [XLEN-1:0] o_mem_wdata,
  output logic [7:0]      o_mem_wstrb,
  output logic            o_mem_wr,
  output logic [XLEN-1:0] o_wb_data
);

  logic [2:0]      ofs;
  logic [5:0]      bit_ofs;
  logic [7:0]      size_mask;
  logic [XLEN-1:0] ld_raw;
  logic [XLEN-1:0] ld_ext;

  assign ofs     = i_addr[2:0];
  assign bit_ofs = {ofs, 3'b000};

  always_comb begin
    case (i_mem_op)
      MOP_SB, MOP_UB: size_mask = 8'h01;
      MOP_SH, MOP_UH: size_mask = 8'h03;
      MOP_SW, MOP_UW: size_mask = 8'h0f;
      MOP_SD:         size_mask = 8'hff;
      default:        size_mask = 8'h00;
    endcase
  end

  assign o_mem_wr    = i_mem_wr & (i_mem_op != MOP_NONE);
  assign o_mem_wstrb = o_mem_wr ? (size_mask << ofs) : 8'h00;
  assign o_mem_wdata = i_rs2 << bit_ofs; // into the addressed lane

  assign ld_raw = i_mem_rdata >> bit_ofs;

  always_comb begin
    case (i_mem_op)
      MOP_SB:  ld_ext = {{56{ld_raw[7]}}, ld_raw[7:0]};
      MOP_UB:  ld_ext = {56'd0, ld_raw[7:0]};
      MOP_SH:  ld_ext = {{48{ld_raw[15]}}, ld_raw[15:0]};
      MOP_UH:  ld_ext = {48'd0, ld_raw[15:0]};
      MOP_SW:  ld_ext = {{32{ld_raw[31]}}, ld_raw[31:0]};
      MOP_UW:  ld_ext = {32'd0, ld_raw[31:0]};
      default: ld_ext = ld_raw;
    endcase
  end

  assign o_wb_data = i_mem_to_reg ? ld_ext : i_alu_res;

endmodule

`default_nettype wire

// File: hdl/rv_regfile.sv
// 32 x 64-bit registers with combinational reads and x0 never written
`timescale 1ns/1ns
`default_nettype none

module rv_regfile
  import rv_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_arst_n,
  input  logic [4:0]      i_ra,
  input  logic [4:0]      i_rb,
  input  logic [4:0]      i_rd,
  input  logic            i_we,
  input  logic [XLEN-1:0] i_wdata,
  output logic [XLEN-1:0] o_rs1,
  output logic [XLEN-1:0] o_rs2
);

  logic [XLEN-1:0] regs [32];

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int k = 0; k < 32; k++) begin
        regs[k] <= '0;
      end
    end else if (i_we && (i_rd != 5'd0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rs1 = regs[i_ra]; // x0 stays at its reset value
  assign o_rs2 = regs[i_rb];

endmodule

`default_nettype wire

// File: hdl/rv_pc_unit.sv
// PC starts at RESET_PC one cycle after reset release and halts until the next reset
`timescale 1ns/1ns
`default_nettype none

module rv_pc_unit
  import rv_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_arst_n,
  input  logic [2:0]      i_branch,
  input  logic            i_br_unsigned,
  input  logic            i_ebreak,
  input  logic            i_illegal,
  input  logic [XLEN-1:0] i_rs1,
  input  logic [XLEN-1:0] i_rs2,
  input  logic [XLEN-1:0] i_imm,
  output logic [XLEN-1:0] o_pc,
  output logic            o_valid,
  output logic            o_halt,
  output logic            o_illegal
);

  logic [XLEN-1:0] pc_q;
  logic [XLEN-1:0] pc_d;
  logic            start_q;
  logic            halt_q;
  logic            ill_q;
  logic            valid;
  logic            eq;
  logic            lt;
  logic            take;

  assign eq = i_rs1 == i_rs2;
  assign lt = i_br_unsigned ? (i_rs1 < i_rs2) : ($signed(i_rs1) < $signed(i_rs2));

  always_comb begin
    case (i_branch)
      BR_JAL:  take = 1'b1;
      BR_EQ:   take = eq;
      BR_NE:   take = !eq;
      BR_LT:   take = lt;
      BR_GE:   take = !lt;
      default: take = 1'b0;
    endcase
  end

  always_comb begin
    if (i_branch == BR_JALR) pc_d = (i_rs1 + i_imm) & ~64'd1;
    else if (take) pc_d = pc_q + i_imm;
    else pc_d = pc_q + 64'd4;
  end

  assign valid = start_q & ~halt_q;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      pc_q    <= RESET_PC;
      start_q <= 1'b0;
      halt_q  <= 1'b0;
      ill_q   <= 1'b0;
    end else begin
      start_q <= 1'b1;
      if (valid) begin
        if (i_ebreak | i_illegal) begin
          halt_q <= 1'b1; // pc holds from here on
          ill_q  <= i_illegal;
        end else begin
          pc_q <= pc_d;
        end
      end
    end
  end

  assign o_pc      = pc_q;
  assign o_valid   = valid;
  assign o_halt    = halt_q;
  assign o_illegal = ill_q;

endmodule

`default_nettype wire

// File: hdl/rv_core.sv
// single-cycle RV64 core and both memories must answer combinationally within the cycle
`timescale 1ns/1ns
`default_nettype none

module rv_core
  import rv_pkg::*;
(
  input  logic            i_clk,
  input  logic            i_arst_n,
  input  logic [31:0]     i_inst,
  input  logic [XLEN-1:0] i_mem_rdata,
  output logic [XLEN-1:0] o_pc,
  output logic [XLEN-1:0] o_mem_addr,
  output logic [XLEN-1:0] o_mem_wdata,
  output logic [7:0]      o_mem_wstrb,
  output logic            o_mem_wr,
  output logic            o_halt,
  output logic            o_illegal
);

  logic [XLEN-1:0] pc;
  logic            valid;
  logic [4:0]      ra;
  logic [4:0]      rb;
  logic [4:0]      rd;
  logic [XLEN-1:0] imm;
  logic            a_src;
  logic [1:0]      b_src;
  logic [4:0]      alu_ctr;
  logic            word_cut;
  logic [2:0]      branch;
  logic            br_unsigned;
  logic            reg_wr;
  logic            mem_wr;
  logic            mem_to_reg;
  logic [2:0]      mem_op;
  logic            ebreak;
  logic            illegal;
  logic [XLEN-1:0] rs1;
  logic [XLEN-1:0] rs2;
  logic [XLEN-1:0] alu_res;
  logic [XLEN-1:0] wb_data;

  rv_pc_unit u_pc (
    .i_clk         (i_clk),
    .i_arst_n      (i_arst_n),
    .i_branch      (branch),
    .i_br_unsigned (br_unsigned),
    .i_ebreak      (ebreak),
    .i_illegal     (illegal),
    .i_rs1         (rs1),
    .i_rs2         (rs2),
    .i_imm         (imm),
    .o_pc          (pc),
    .o_valid       (valid),
    .o_halt        (o_halt),
    .o_illegal     (o_illegal)
  );

  rv_idu u_idu (
    .i_inst        (i_inst),
    .i_valid       (valid),
    .o_ra          (ra),
    .o_rb          (rb),
    .o_rd          (rd),
    .o_imm         (imm),
    .o_a_src       (a_src),
    .o_b_src       (b_src),
    .o_alu_ctr     (alu_ctr),
    .o_word_cut    (word_cut),
    .o_branch      (branch),
    .o_br_unsigned (br_unsigned),
    .o_reg_wr      (reg_wr),
    .o_mem_wr      (mem_wr),
    .o_mem_to_reg  (mem_to_reg),
    .o_mem_op      (mem_op),
    .o_ebreak      (ebreak),
    .o_illegal     (illegal)
  );

  rv_regfile u_rf (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_ra     (ra),
    .i_rb     (rb),
    .i_rd     (rd),
    .i_we     (reg_wr),
    .i_wdata  (wb_data),
    .o_rs1    (rs1),
    .o_rs2    (rs2)
  );

  rv_alu u_alu (
    .i_pc       (pc),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .i_imm      (imm),
    .i_a_src    (a_src),
    .i_b_src    (b_src),
    .i_alu_ctr  (alu_ctr),
    .i_word_cut (word_cut),
    .o_result   (alu_res)
  );

  rv_lsu u_lsu (
    .i_addr       (alu_res),
    .i_rs2        (rs2),
    .i_mem_op     (mem_op),
    .i_mem_wr     (mem_wr),
    .i_mem_to_reg (mem_to_reg),
    .i_alu_res    (alu_res),
    .i_mem_rdata  (i_mem_rdata),
    .o_mem_wdata  (o_mem_wdata),
    .o_mem_wstrb  (o_mem_wstrb),
    .o_mem_wr     (o_mem_wr),
    .o_wb_data    (wb_data)
  );

  assign o_pc       = pc;
  assign o_mem_addr = alu_res;

endmodule

`default_nettype wire

// File: tb/tb_clkgen.sv
// free-running 40 ns clock with reset held low for the first 4 cycles
`timescale 1ns/1ns
`default_nettype none

module tb_clkgen (
  output logic o_clk,
  output logic o_arst_n
);

  initial o_clk = 1'b0;
  always #20 o_clk = ~o_clk;

  initial begin
    o_arst_n = 1'b0;
    repeat (4) @(posedge o_clk);
    #2 o_arst_n = 1'b1; // released off the edge
  end

endmodule

`default_nettype wire

// File: tb/tb_core.sv
// memories are 64 words of code at RESET_PC and 64 doublewords of data at address 0
`timescale 1ns/1ns
`default_nettype none

module tb_core
  import rv_pkg::*;
();

  localparam int NUM_TESTS = 5;

  logic        clk, gen_rst_n, tb_rst_n, arst_n;
  logic [31:0] imem [64];
  logic [63:0] dmem [64];
  logic [63:0] o_pc, o_mem_addr, o_mem_wdata, exp [32];
  logic [7:0]  o_mem_wstrb;
  logic        o_mem_wr, o_halt, o_illegal;
  logic [7:0]  strb_log [$];
  logic [63:0] addr_log [$];
  int          errors, wp, store_count;
  integer      seed = 28;

  assign arst_n = gen_rst_n & tb_rst_n;

  tb_clkgen u_clk (.o_clk(clk), .o_arst_n(gen_rst_n));

  rv_core i_dut (
    .i_clk(clk), .i_arst_n(arst_n),
    .i_inst(imem[o_pc[7:2]]), .i_mem_rdata(dmem[o_mem_addr[8:3]]),
    .o_pc(o_pc), .o_mem_addr(o_mem_addr), .o_mem_wdata(o_mem_wdata),
    .o_mem_wstrb(o_mem_wstrb), .o_mem_wr(o_mem_wr), .o_halt(o_halt), .o_illegal(o_illegal)
  );

  always @(posedge clk) begin
    if (arst_n && o_mem_wr) begin
      for (int b = 0; b < 8; b++) begin
        if (o_mem_wstrb[b]) dmem[o_mem_addr[8:3]][8*b +: 8] <= o_mem_wdata[8*b +: 8];
      end
      strb_log.push_back(o_mem_wstrb);
      addr_log.push_back(o_mem_addr);
      store_count++;
    end
  end

  initial begin
    #(NUM_TESTS * 200 * 40);
    $display("watchdog expired before the tests finished");
    $display("Something failed");
    $finish;
  end

  function automatic logic [63:0] sext32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic logic [63:0] fill_word(input int k);
    return 64'h9E37_79B9_7F4A_7C15 * (k + 1); // differs for every index
  endfunction

  function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE};
  endfunction

  function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                         input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[wp] = w;
    wp++;
  endtask

  task automatic load_const(input logic [4:0] rd, input logic [31:0] v);
    logic [31:0] hi;
    hi = (v + 32'h800) >> 12;
    emit({hi[19:0], rd, OPC_LUI});
    emit(i_type(v[11:0], rd, 3'b000, rd, OPC_OPIMM32)); // addiw fixes the carry
  endtask

  task automatic prepare();
    for (int k = 0; k < 64; k++) begin
      imem[k] = 32'h0010_0073; // ebreak
      dmem[k] = fill_word(k);
    end
    wp = 0;
  endtask

  task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] want);
    assert (got === want) else begin
      errors++;
      $display("Mismatch %s: got %h expected %h", name, got, want);
    end
  endtask

  task automatic pulse_reset();
    @(posedge clk);
    #2 tb_rst_n = 1'b0;
    repeat (4) @(posedge clk);
    #2 tb_rst_n = 1'b1;
    strb_log.delete();
    addr_log.delete();
    store_count = 0;
  endtask

  task automatic run_until_halt(input int limit);
    int n;
    n = 0;
    while (!o_halt && n < limit) begin
      @(posedge clk);
      #2 n++;
    end
    assert (o_halt) else begin
      errors++;
      $display("program did not halt within %0d cycles", limit);
    end
  endtask

  task automatic reset_values_test();
    prepare();
    emit(s_type(12'h100, 0, 0, 3'b011)); // a store waits at the reset vector
    pulse_reset();
    check_val("o_pc", o_pc, RESET_PC);
    check_val("o_mem_wr", o_mem_wr, 0);
    check_val("o_halt", o_halt, 0);
    check_val("o_illegal", o_illegal, 0);
  endtask

  task automatic alu_ops_test();
    logic [31:0] r1, r2;
    logic [63:0] a1, a2, x6;
    int          sa, sb, pc_idx;
    r1 = $random(seed);
    r2 = $random(seed);
    a1 = sext32(r1);
    a2 = sext32(r2);
    x6 = (a1 << 32) + a2;
    sa = x6[31:0];
    sb = r1;
    prepare();
    load_const(1, r1);
    load_const(2, r2);
    emit(i_type(12'd32, 1, 3'b001, 5, OPC_OPIMM)); // slli
    emit(r_type(7'h00, 2, 5, 3'b000, 6, OPC_OP));
    emit(r_type(7'h20, 1, 6, 3'b000, 7, OPC_OP));
    emit(r_type(7'h00, 2, 6, 3'b110, 8, OPC_OP));
    emit(i_type(12'hFAB, 6, 3'b100, 9, OPC_OPIMM));
    emit(i_type(12'h3C5, 6, 3'b111, 10, OPC_OPIMM));
    emit(i_type(12'hFFF, 1, 3'b011, 11, OPC_OPIMM));
    emit(i_type(12'd13, 6, 3'b101, 12, OPC_OPIMM));
    emit(i_type(12'h428, 6, 3'b101, 13, OPC_OPIMM)); // srai 40
    emit(r_type(7'h00, 2, 1, 3'b000, 14, OPC_OP32));
    emit(r_type(7'h20, 2, 1, 3'b000, 15, OPC_OP32));
    emit(r_type(7'h00, 2, 6, 3'b001, 16, OPC_OP32));
    emit(r_type(7'h01, 1, 6, 3'b000, 17, OPC_OP));
    emit(r_type(7'h01, 2, 1, 3'b000, 18, OPC_OP32));
    emit(r_type(7'h01, 1, 6, 3'b100, 19, OPC_OP32));
    emit(r_type(7'h01, 1, 6, 3'b110, 20, OPC_OP32));
    emit(r_type(7'h01, 0, 1, 3'b100, 21, OPC_OP32)); // divide by zero
    emit(r_type(7'h01, 0, 1, 3'b110, 22, OPC_OP32));
    pc_idx = wp;
    emit({20'h12345, 5'd23, OPC_AUIPC});
    emit({20'hABCDE, 5'd24, OPC_LUI});
    emit(i_type(12'hFF9, 2, 3'b000, 25, OPC_OPIMM));
    for (int k = 7; k <= 25; k++) emit(s_type(12'h100 + 8 * (k - 7), k, 0, 3'b011));
    exp[7]  = x6 - a1;
    exp[8]  = x6 | a2;
    exp[9]  = x6 ^ 64'hFFFF_FFFF_FFFF_FFAB;
    exp[10] = x6 & 64'h3C5;
    exp[11] = (a1 < 64'hFFFF_FFFF_FFFF_FFFF) ? 64'd1 : 64'd0;
    exp[12] = x6 >> 13;
    exp[13] = $signed(x6) >>> 40;
    exp[14] = sext32(r1 + r2);
    exp[15] = sext32(r1 - r2);
    exp[16] = sext32(x6[31:0] << r2[4:0]);
    exp[17] = x6 * a1;
    exp[18] = sext32(r1 * r2);
    exp[19] = (sb == 0) ? '1 : sext32(sa / sb);
    exp[20] = (sb == 0) ? sext32(sa) : sext32(sa % sb);
    exp[21] = '1;
    exp[22] = a1;
    exp[23] = RESET_PC + 4 * pc_idx + sext32(32'h1234_5000);
    exp[24] = sext32(32'hABCD_E000);
    exp[25] = a2 - 64'd7;
    pulse_reset();
    run_until_halt(150);
    for (int k = 7; k <= 25; k++) check_val($sformatf("x%0d", k), dmem[25 + k], exp[k]);
  endtask

  task automatic load_store_test();
    logic [31:0] r1, r2;
    logic [63:0] x6, m11, m12, m13;
    logic [7:0]  strb_exp [4];
    logic [63:0] addr_exp [4];
    r1 = $random(seed) | 32'h8000_8000; // negative word and half
    r2 = $random(seed) & 32'h7FFF_7FFF;
    x6 = {r1, r2};
    m11 = fill_word(17);
    m11[63:32] = r1;
    m12 = fill_word(18);
    m12[31:16] = r2[15:0];
    m13 = fill_word(19);
    m13[63:56] = r2[7:0];
    strb_exp = '{8'hFF, 8'hF0, 8'h0C, 8'h80};
    addr_exp = '{64'h80, 64'h8C, 64'h92, 64'h9F};
    prepare();
    load_const(1, r1);
    load_const(2, r2);
    emit(i_type(12'd32, 1, 3'b001, 5, OPC_OPIMM));
    emit(r_type(7'h00, 2, 5, 3'b110, 6, OPC_OP)); // or keeps both halves
    emit(s_type(12'h080, 6, 0, 3'b011));
    emit(s_type(12'h08C, 1, 0, 3'b010));
    emit(s_type(12'h092, 2, 0, 3'b001));
    emit(s_type(12'h09F, 2, 0, 3'b000));
    emit(i_type(12'h086, 0, 3'b001, 10, OPC_LOAD));
    emit(i_type(12'h086, 0, 3'b101, 11, OPC_LOAD));
    emit(i_type(12'h084, 0, 3'b010, 12, OPC_LOAD));
    emit(i_type(12'h087, 0, 3'b100, 13, OPC_LOAD));
    emit(i_type(12'h080, 0, 3'b011, 14, OPC_LOAD));
    emit(i_type(12'h092, 0, 3'b001, 15, OPC_LOAD));
    for (int k = 10; k <= 15; k++) emit(s_type(12'h100 + 8 * (k - 10), k, 0, 3'b011));
    pulse_reset();
    run_until_halt(150);
    for (int k = 0; k < 4; k++) begin
      check_val("o_mem_wstrb", strb_log[k], strb_exp[k]);
      check_val("o_mem_addr", addr_log[k], addr_exp[k]);
    end
    check_val("dmem[0x80]", dmem[16], x6);
    check_val("dmem[0x88]", dmem[17], m11);
    check_val("dmem[0x90]", dmem[18], m12);
    check_val("dmem[0x98]", dmem[19], m13);
    check_val("lh", dmem[32], {{48{r1[31]}}, r1[31:16]});
    check_val("lhu", dmem[33], {48'd0, r1[31:16]});
    check_val("lw", dmem[34], sext32(r1));
    check_val("lbu", dmem[35], {56'd0, r1[31:24]});
    check_val("ld", dmem[36], x6);
    check_val("lh low", dmem[37], {48'd0, r2[15:0]});
  endtask

  task automatic branch_test();
    logic [2:0]  f3 [12];
    logic [4:0]  ra [12];
    logic [4:0]  rb [12];
    logic [63:0] v [4];
    logic        taken;
    int          pc_a;
    v = '{64'd0, '1, 64'd1, 64'd1}; // x1 = -1, x2 = x3 = 1
    f3 = '{0, 0, 1, 1, 4, 4, 5, 5, 6, 6, 7, 7};
    ra = '{2, 1, 1, 2, 1, 2, 2, 1, 2, 1, 1, 2};
    rb = '{3, 2, 2, 3, 2, 1, 1, 2, 1, 2, 2, 1};
    prepare();
    emit(i_type(12'hFFF, 0, 3'b000, 1, OPC_OPIMM));
    emit(i_type(12'd1, 0, 3'b000, 2, OPC_OPIMM));
    emit(i_type(12'd1, 0, 3'b000, 3, OPC_OPIMM));
    for (int k = 0; k < 12; k++) begin
      emit(b_type(13'd8, rb[k], ra[k], f3[k]));
      emit(i_type(k + 1, 0, 3'b000, 10 + k, OPC_OPIMM)); // marker on fall-through
      case (f3[k])
        0: taken = v[ra[k]] == v[rb[k]];
        1: taken = v[ra[k]] != v[rb[k]];
        4: taken = $signed(v[ra[k]]) < $signed(v[rb[k]]);
        5: taken = $signed(v[ra[k]]) >= $signed(v[rb[k]]);
        6: taken = v[ra[k]] < v[rb[k]];
        default: taken = v[ra[k]] >= v[rb[k]];
      endcase
      exp[10 + k] = taken ? 64'd0 : k + 1;
    end
    exp[22] = RESET_PC + 4 * wp + 4;
    emit({1'b0, 10'd4, 1'b0, 8'd0, 5'd22, OPC_JAL}); // jal +8
    emit(i_type(12'd99, 0, 3'b000, 23, OPC_OPIMM));
    pc_a = wp;
    emit({20'd0, 5'd24, OPC_AUIPC});
    emit(i_type(12'd13, 24, 3'b000, 25, OPC_JALR)); // bit 0 dropped
    emit(i_type(12'd77, 0, 3'b000, 26, OPC_OPIMM));
    exp[23] = 0;
    exp[24] = RESET_PC + 4 * pc_a;
    exp[25] = RESET_PC + 4 * pc_a + 8;
    exp[26] = 0;
    for (int k = 10; k <= 26; k++) emit(s_type(12'h100 + 8 * (k - 10), k, 0, 3'b011));
    pulse_reset();
    run_until_halt(150);
    for (int k = 10; k <= 26; k++) check_val($sformatf("x%0d", k), dmem[22 + k], exp[k]);
  endtask

  task automatic halt_test();
    logic [63:0] pc_held;
    int          stores;
    prepare();
    emit(i_type(12'd5, 0, 3'b000, 1, OPC_OPIMM));
    emit(32'h0010_0073);
    emit(s_type(12'h100, 1, 0, 3'b011)); // must never run
    pulse_reset();
    run_until_halt(50);
    check_val("o_illegal", o_illegal, 0);
    check_val("o_pc", o_pc, RESET_PC + 4);
    pc_held = o_pc;
    stores = store_count;
    repeat (5) @(posedge clk);
    #2 check_val("o_pc", o_pc, pc_held);
    check_val("store count", store_count, stores);
    check_val("dmem[0x100]", dmem[32], fill_word(32));
    prepare();
    emit(i_type(12'd5, 0, 3'b000, 1, OPC_OPIMM));
    emit(32'hFFFF_FFFF);
    pulse_reset();
    run_until_halt(50);
    check_val("o_halt", o_halt, 1);
    check_val("o_illegal", o_illegal, 1);
  endtask

  initial begin
    tb_rst_n = 1'b1;
    errors = 0;
    store_count = 0;
    prepare();
    reset_values_test();
    alu_ops_test();
    load_store_test();
    branch_test();
    halt_test();
    $display("%0d errors", errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: all.f
common/rv_pkg.sv
idu/rv_idu.sv
exu/rv_alu.sv
exu/rv_lsu.sv
hdl/rv_regfile.sv
hdl/rv_pc_unit.sv
hdl/rv_core.sv
tb/tb_clkgen.sv
tb/tb_core.sv

// File: Makefile
SRCS := $(shell cat all.f)

.PHONY: run clean

obj_dir/Vtb_core: all.f $(SRCS)
	verilator --binary --timing --top-module tb_core -f all.f -o Vtb_core

sim.log: obj_dir/Vtb_core
	./obj_dir/Vtb_core > sim.log || true

run: obj_dir/Vtb_core
	./obj_dir/Vtb_core > sim.log || true
	cat sim.log
	grep -qx "Everything OK" sim.log

clean:
	rm -rf obj_dir sim.log
